/* compile.f */
+incdir+common
common/axi_pkg.sv
common/icache_pkg.sv
icache/icache_tags.sv
icache/icache_data.sv
icache/icache_ctrl.sv
verilog/icache_top.sv
verification/tb_icache.sv

/* run.sh */
#!/usr/bin/env bash
# Build the icache testbench with Verilator and run it
# The exit status follows the simulation result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module tb_icache -f compile.f -o tb_icache &&
./obj_dir/tb_icache ||
{ echo "icache simulation did not complete successfully"; exit 1; }

/* verification/tb_icache.sv */
`timescale 1ns/10ps
`include "icache_defines.svh"

module tb_icache
    import icache_pkg::*;
    import axi_pkg::*;
;

    typedef struct packed {
        logic        is_flush;
        logic [31:0] addr;
        logic        miss;
    } stim_t;

    localparam int          NUM_STIM  = 18;
    localparam int          LIMIT     = 40 * NUM_STIM + 20;
    localparam logic [31:0] DATA_KEY  = 32'h5A5A_C3C3;

    // Index 0 tag swap, flush, error lines and a few other indexes
    localparam stim_t STIM [NUM_STIM] = '{
        '{1'b0, 32'h0000_1000, 1'b1},
        '{1'b0, 32'h0000_1004, 1'b0},
        '{1'b0, 32'h0000_1008, 1'b0},
        '{1'b0, 32'h0000_100C, 1'b0},
        '{1'b0, 32'h0000_2000, 1'b1},
        '{1'b0, 32'h0000_1000, 1'b1},
        '{1'b0, 32'h0000_1024, 1'b1},
        '{1'b0, 32'h0000_1028, 1'b0},
        '{1'b1, 32'h0000_0000, 1'b0},
        '{1'b0, 32'h0000_1024, 1'b1},
        '{1'b0, 32'h0000_1000, 1'b1},
        '{1'b0, 32'h8000_0040, 1'b1},
        '{1'b0, 32'h8000_0040, 1'b1},
        '{1'b0, 32'h0000_1004, 1'b0},
        '{1'b0, 32'h0000_30F0, 1'b1},
        '{1'b0, 32'h0000_30FC, 1'b0},
        '{1'b0, 32'h0000_1030, 1'b1},
        '{1'b0, 32'h0000_1034, 1'b0}
    };

    logic        clk;
    logic        rst;
    fetch_req_t  fetch_req;
    fetch_rsp_t  fetch_rsp;
    logic        flush;
    axi_ar_t     m_ar;
    logic        m_arready;
    axi_r_t      m_r;
    logic        m_rready;

    logic [7:0]  lfsr_q;
    logic [31:0] cur_addr;
    int          ar_count;
    int          cycles;

    icache_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp),
        .flush     (flush),
        .m_ar      (m_ar),
        .m_arready (m_arready),
        .m_r       (m_r),
        .m_rready  (m_rready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Taps 8,6,5,4
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic draw_delay(output int d);
        logic [1:0] bits;
        for (int k = 0; k < 2; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            bits[k] = lfsr_q[0];
        end
        d = int'(bits);
    endtask

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return {2'b00, addr[31:2]} ^ DATA_KEY;
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "check on %s", name);
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", LIMIT);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    // AXI read slave with random arready and rvalid delays
    initial begin : axi_mem
        logic [31:0] base;
        axi_r_t      beat_r;
        int          delay;
        forever begin
            @(negedge clk);
            if (m_ar.arvalid) begin
                base = m_ar.araddr;
                check("m_ar.araddr", base, {cur_addr[31:4], 4'h0});
                check("m_ar.arlen", 32'(m_ar.arlen), 32'(`ICACHE_LINE_WORDS - 1));
                check("m_ar.arsize", 32'(m_ar.arsize), 32'd2);
                check("m_ar.arburst", 32'(m_ar.arburst), 32'(AXI_BURST_INCR));
                check("m_ar.arid", 32'(m_ar.arid), 32'd0);
                draw_delay(delay);
                repeat (delay) @(posedge clk);
                @(posedge clk);
                m_arready <= 1'b1;
                @(posedge clk);
                m_arready <= 1'b0;
                ar_count = ar_count + 1;
                for (int b = 0; b < 4; b++) begin
                    draw_delay(delay);
                    m_r <= '0;
                    repeat (delay) @(posedge clk);
                    beat_r = '0;
                    beat_r.rvalid = 1'b1;
                    beat_r.rdata = mem_word(base + 32'(4 * b));
                    beat_r.rresp = (b == 2 && base[31]) ? AXI_SLVERR : AXI_OKAY;
                    beat_r.rlast = (b == 3);
                    m_r <= beat_r;
                    // Beat stays on the bus until rready
                    @(negedge clk);
                    while (!m_rready) begin
                        @(negedge clk);
                    end
                    @(posedge clk);
                end
                m_r <= '0;
            end
        end
    end

    task automatic wait_idle();
        @(negedge clk);
        while (fetch_rsp.stall) begin
            @(negedge clk);
        end
    endtask

    initial begin : stimulus
        int ar_before;
        int latency;
        rst       = 1'b1;
        fetch_req = '0;
        flush     = 1'b0;
        m_arready = 1'b0;
        m_r       = '0;
        lfsr_q    = 8'd4;
        cur_addr  = '0;
        ar_count  = 0;
        cycles    = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check("fetch_rsp.stall", 32'(fetch_rsp.stall), 32'd1);
        check("fetch_rsp.valid", 32'(fetch_rsp.valid), 32'd0);
        check("fetch_rsp.error", 32'(fetch_rsp.error), 32'd0);
        check("m_ar.arvalid", 32'(m_ar.arvalid), 32'd0);
        check("m_rready", 32'(m_rready), 32'd0);

        for (int i = 0; i < NUM_STIM; i++) begin
            wait_idle();
            ar_before = ar_count;
            if (STIM[i].is_flush) begin
                @(posedge clk);
                flush <= 1'b1;
                @(posedge clk);
                flush <= 1'b0;
                @(negedge clk);
                check("fetch_rsp.stall", 32'(fetch_rsp.stall), 32'd0);
            end else begin
                cur_addr = STIM[i].addr;
                @(posedge clk);
                fetch_req.read     <= 1'b1;
                fetch_req.addr.raw <= STIM[i].addr;
                // Acceptance edge
                @(posedge clk);
                fetch_req.read <= 1'b0;
                @(negedge clk);
                latency = 1;
                while (!fetch_rsp.valid) begin
                    @(negedge clk);
                    latency = latency + 1;
                end
                check("fetch_rsp.stall", 32'(fetch_rsp.stall), 32'd1);
                check("fetch_rsp.error", 32'(fetch_rsp.error), 32'(STIM[i].addr[31]));
                if (!STIM[i].addr[31]) begin
                    check("fetch_rsp.rdata", fetch_rsp.rdata, mem_word(STIM[i].addr));
                end
                if (!STIM[i].miss) begin
                    check("hit latency", 32'(latency), 32'd1);
                end
            end
            check("ar count delta", 32'(ar_count - ar_before), 32'(STIM[i].miss));
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

/* verilog/icache_top.sv */
`timescale 1ns/10ps

module icache_top
    import icache_pkg::*;
    import axi_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  fetch_req_t fetch_req,
    output fetch_rsp_t fetch_rsp,
    input  logic       flush,
    output axi_ar_t    m_ar,
    input  logic       m_arready,
    input  axi_r_t     m_r,
    output logic       m_rready
);

    fetch_addr_t lookup_addr;
    logic        hit;
    logic [31:0] line_word;
    logic        beat_we;
    logic [1:0]  beat_idx;
    logic        validate;
    logic        store_flush;

    icache_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .req         (fetch_req),
        .rsp         (fetch_rsp),
        .flush       (flush),
        .ar          (m_ar),
        .arready     (m_arready),
        .r           (m_r),
        .rready      (m_rready),
        .hit         (hit),
        .line_word   (line_word),
        .lookup_addr (lookup_addr),
        .beat_we     (beat_we),
        .beat_idx    (beat_idx),
        .validate    (validate),
        .store_flush (store_flush)
    );

    icache_tags u_tags (
        .clk      (clk),
        .rst      (rst),
        .addr     (lookup_addr),
        .validate (validate),
        .flush    (store_flush),
        .hit      (hit)
    );

    // Refill data comes straight off the R channel
    icache_data u_data (
        .clk       (clk),
        .addr      (lookup_addr),
        .beat_we   (beat_we),
        .beat_idx  (beat_idx),
        .beat_data (m_r.rdata),
        .rdata     (line_word)
    );

endmodule

/* icache/icache_ctrl.sv */
`timescale 1ns/10ps
`include "icache_defines.svh"

module icache_ctrl
    import icache_pkg::*;
    import axi_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  fetch_req_t  req,
    output fetch_rsp_t  rsp,
    input  logic        flush,
    output axi_ar_t     ar,
    input  logic        arready,
    input  axi_r_t      r,
    output logic        rready,
    input  logic        hit,
    input  logic [31:0] line_word,
    output fetch_addr_t lookup_addr,
    output logic        beat_we,
    output logic [1:0]  beat_idx,
    output logic        validate,
    output logic        store_flush
);

    ctrl_state_t state;
    ctrl_state_t state_d;
    fetch_addr_t addr_q;
    logic [1:0]  beat_cnt;
    logic        err_q;
    logic        accept;
    logic        beat;
    logic        beat_ok;

    assign accept  = (state == IDLE) && req.read;
    assign beat    = (state == RECV) && r.rvalid;
    assign beat_ok = (r.rresp == AXI_OKAY);

    always_comb begin
        state_d = state;
        case (state)
            FLUSH: begin
                state_d = IDLE;
            end
            IDLE: begin
                if (req.read) begin
                    state_d = CMP;
                end
            end
            CMP: begin
                // Answer on hit or on a failed refill, else fetch the line
                if (hit || err_q) begin
                    state_d = IDLE;
                end else begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                if (arready) begin
                    state_d = RECV;
                end
            end
            RECV: begin
                if (beat && r.rlast) begin
                    state_d = CMP;
                end
            end
            default: begin
                state_d = FLUSH;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= FLUSH;
            beat_cnt <= '0;
            err_q    <= 1'b0;
        end else begin
            state <= state_d;
            if (accept) begin
                err_q <= 1'b0;
            end else if (beat && !beat_ok) begin
                err_q <= 1'b1;
            end
            if (state == REFILL) begin
                beat_cnt <= '0;
            end else if (beat) begin
                beat_cnt <= beat_cnt + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= req.addr;
        end
    end

    assign rsp.stall = (state != IDLE);
    assign rsp.valid = (state == CMP) && (hit || err_q);
    assign rsp.error = (state == CMP) && err_q;
    assign rsp.rdata = line_word;

    always_comb begin
        ar         = '0;
        ar.arvalid = (state == REFILL);
        ar.araddr  = {addr_q.raw[`ICACHE_ADDR_WIDTH-1:`ICACHE_LINE_OFFSET],
                      {`ICACHE_LINE_OFFSET{1'b0}}};
        ar.arlen   = 8'(`ICACHE_LINE_WORDS - 1);
        // 4 bytes per beat
        ar.arsize  = 3'd2;
        ar.arburst = AXI_BURST_INCR;
        // Unprivileged, secure, instruction access
        ar.arprot  = 3'b100;
    end

    assign rready      = (state == RECV);
    assign lookup_addr = addr_q;
    assign beat_we     = beat;
    assign beat_idx    = beat_cnt;
    assign validate    = beat && r.rlast && beat_ok && !err_q;
    assign store_flush = (state == FLUSH) || ((state == IDLE) && flush);

    a_ar_stable: assert property (
        @(posedge clk) disable iff (rst)
        ar.arvalid && !arready |=> ar.arvalid && $stable(ar.araddr)
    );

    a_valid_single: assert property (
        @(posedge clk) disable iff (rst)
        rsp.valid |=> !rsp.valid
    );

    // Slave ends the burst after exactly arlen+1 beats
    a_rlast_on_final_beat: assert property (
        @(posedge clk) disable iff (rst)
        beat |-> (r.rlast == (beat_cnt == 2'(`ICACHE_LINE_WORDS - 1)))
    );

endmodule

/* icache/icache_data.sv */
`timescale 1ns/10ps
`include "icache_defines.svh"

module icache_data
    import icache_pkg::*;
(
    input  logic        clk,
    input  fetch_addr_t addr,
    input  logic        beat_we,
    input  logic [1:0]  beat_idx,
    input  logic [31:0] beat_data,
    output logic [31:0] rdata
);

    logic [31:0] lines [`ICACHE_LINES][`ICACHE_LINE_WORDS];

    // Refill beats land in the line being looked up
    always_ff @(posedge clk) begin
        if (beat_we) begin
            lines[addr.fields.index][beat_idx] <= beat_data;
        end
    end

    // Word select for the CPU response
    assign rdata = lines[addr.fields.index][addr.fields.word];

endmodule

/* icache/icache_tags.sv */
`timescale 1ns/10ps
`include "icache_defines.svh"

module icache_tags
    import icache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  fetch_addr_t addr,
    input  logic        validate,
    input  logic        flush,
    output logic        hit
);

    logic [`ICACHE_TAG_BITS-1:0] tags [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0]    valid;
    logic [`ICACHE_TAG_BITS-1:0] line_tag;

    // Valid bits clear on reset and on flush
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
        end else if (flush) begin
            valid <= '0;
        end else if (validate) begin
            valid[addr.fields.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (validate) begin
            tags[addr.fields.index] <= addr.fields.tag;
        end
    end

    assign line_tag = tags[addr.fields.index];

    // Lookup on the registered fetch address
    assign hit = valid[addr.fields.index] && (line_tag == addr.fields.tag);

    // Controller validates only in RECV and flushes only in FLUSH or IDLE
    a_no_validate_on_flush: assert property (
        @(posedge clk) disable iff (rst)
        !(validate && flush)
    );

endmodule

/* common/icache_pkg.sv */
`include "icache_defines.svh"

package icache_pkg;

    // Lookup view of a fetch address
    typedef struct packed {
        logic [`ICACHE_TAG_BITS-1:0]   tag;
        logic [`ICACHE_INDEX_BITS-1:0] index;
        logic [`ICACHE_WORD_BITS-1:0]  word;
        logic [`ICACHE_BYTE_BITS-1:0]  byte_off;
    } fetch_fields_t;

    // Same word seen as a bus address or as lookup fields
    typedef union packed {
        logic [`ICACHE_ADDR_WIDTH-1:0] raw;
        fetch_fields_t                 fields;
    } fetch_addr_t;

    typedef struct packed {
        logic        read;
        fetch_addr_t addr;
    } fetch_req_t;

    typedef struct packed {
        logic        stall;
        logic        valid;
        logic        error;
        logic [31:0] rdata;
    } fetch_rsp_t;

    typedef enum logic [2:0] {
        FLUSH,
        IDLE,
        CMP,
        REFILL,
        RECV
    } ctrl_state_t;

endpackage

/* common/axi_pkg.sv */
`include "icache_defines.svh"

package axi_pkg;

    typedef enum logic [1:0] {
        AXI_OKAY   = 2'b00,
        AXI_EXOKAY = 2'b01,
        AXI_SLVERR = 2'b10,
        AXI_DECERR = 2'b11
    } axi_resp_e;

    typedef enum logic [1:0] {
        AXI_BURST_FIXED = 2'b00,
        AXI_BURST_INCR  = 2'b01,
        AXI_BURST_WRAP  = 2'b10
    } axi_burst_e;

    // Read address channel, master to slave
    typedef struct packed {
        logic                          arvalid;
        logic [`ICACHE_ADDR_WIDTH-1:0] araddr;
        logic [7:0]                    arlen;
        logic [2:0]                    arsize;
        logic [1:0]                    arburst;
        logic [3:0]                    arid;
        logic [3:0]                    arcache;
        logic [2:0]                    arprot;
    } axi_ar_t;

    // Read data beat, slave to master
    typedef struct packed {
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rlast;
        logic [3:0]  rid;
    } axi_r_t;

endpackage

/* common/icache_defines.svh */
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// Byte address width on both the fetch port and AXI
`define ICACHE_ADDR_WIDTH 32

// Direct mapped geometry
`define ICACHE_LINES 16
`define ICACHE_LINE_WORDS 4

// Word offset inside a line, bytes inside a word
`define ICACHE_WORD_BITS $clog2(`ICACHE_LINE_WORDS)
`define ICACHE_BYTE_BITS 2

// Lookup fields
`define ICACHE_INDEX_BITS $clog2(`ICACHE_LINES)
`define ICACHE_TAG_BITS (`ICACHE_ADDR_WIDTH - `ICACHE_INDEX_BITS - `ICACHE_WORD_BITS - `ICACHE_BYTE_BITS)

// Bits cleared for a line-aligned refill address
`define ICACHE_LINE_OFFSET (`ICACHE_WORD_BITS + `ICACHE_BYTE_BITS)

`endif
